//--- Makefile
TOOL   := verilator
FLAGS  := --binary --assert -Wno-fatal
TOP    := tb_sprite_unit
FLIST  := files.f
OBJDIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation with $(TOOL)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- dv/sprite_tb_tasks.svh
`ifndef SPRITE_TB_TASKS_SVH
`define SPRITE_TB_TASKS_SVH

logic [7:0] attr_model [256];        // mirror of the attribute file
sl_pixel_t  pal_model [256];         // mirror of the palette
sl_pixel_t  ref_line [LINE_PIXELS];  // expected display of one line

// ----------------------------------------------------------------------
// configuration writers
// ----------------------------------------------------------------------
task automatic write_cfg(input logic [1:0] sel, input logic [7:0] addr, input logic [7:0] data);
	@(negedge clk);
	cfg = '{we: 1'b1, sel: sel, addr: addr, data: data};
	@(negedge clk);
	cfg = '0;
endtask

task automatic write_attr(input logic [7:0] addr, input logic [7:0] data);
	attr_model[addr] = data;
	write_cfg(CFG_SEL_ATTR, addr, data);
endtask

task automatic write_pal(input logic [7:0] idx, input sl_pixel_t p);
	pal_model[idx] = p;
	write_cfg(CFG_SEL_PAL, idx, {1'b0, p}); // bit 6 is the opaque flag
endtask

task automatic set_sprite(input logic [4:0] s, input logic [8:0] x, input logic [8:0] y,
	input logic [6:0] w, input logic [6:0] h, input logic [5:0] pb, input cres_e cr,
	input logic [MEM_AW-1:0] base);
	write_attr({s, 3'd0}, x[7:0]);
	write_attr({s, 3'd1}, {x[8], w});
	write_attr({s, 3'd2}, y[7:0]);
	write_attr({s, 3'd3}, {y[8], h}); // h in units of four lines
	write_attr({s, 3'd4}, {pb, cr});
	write_attr({s, 3'd5}, base[7:0]);
	write_attr({s, 3'd6}, base[15:8]);
	write_attr({s, 3'd7}, {3'b000, base[20:16]});
endtask

task automatic clear_sprites();
	for (int s = 0; s < NUM_SPRITES; s++)
		write_attr(8'(s * 8 + 4), 8'h00); // CRES_OFF
endtask

task automatic init_config();
	for (int a = 0; a < 256; a++)
		write_attr(8'(a), 8'h00);
	for (int a = 0; a < 256; a++)
		write_pal(8'(a), '0);  // all transparent
endtask

function automatic logic [15:0] read_word(input logic [MEM_AW-1:0] addr);
	if (words.exists(addr))
		return words[addr];
	return 16'h0000;           // unwritten words read as zero
endfunction

// ----------------------------------------------------------------------
// reference line model
// ----------------------------------------------------------------------
task automatic build_ref(input vline_t v);
	sl_pixel_t         row [LB_DEPTH];
	logic [7:0]        b [8];
	logic [8:0]        sx, sy, px_x;
	logic [6:0]        w, h;
	logic [5:0]        pb;
	cres_e             cr;
	logic [MEM_AW-1:0] base, addr;
	logic [15:0]       word;
	sl_pixel_t         p;
	int                lidx, npw;
	for (int i = 0; i < LB_DEPTH; i++)
		row[i] = '0;
	for (int s = 0; s < NUM_SPRITES; s++)
	begin
		for (int n = 0; n < 8; n++)
			b[n] = attr_model[s * 8 + n];
		sx   = {b[1][7], b[0]};
		w    = b[1][6:0];
		sy   = {b[3][7], b[2]};
		h    = b[3][6:0];
		pb   = b[4][7:2];
		cr   = cres_e'(b[4][1:0]);
		base = {b[7][4:0], b[6], b[5]};
		if (cr != CRES_OFF && int'(v) >= int'(sy) && int'(v) < int'(sy) + 4 * int'(h))
		begin
			lidx = int'(v) - int'(sy);      // line within the sprite
			npw  = (cr == CRES_4C) ? 8 : (cr == CRES_16C) ? 4 : 2;
			px_x = sx;
			for (int k = 0; k < int'(w); k++)
			begin
				addr = base + MEM_AW'(lidx * int'(w) + k);
				word = read_word(addr);
				for (int j = 0; j < npw; j++)
				begin
					case (cr)
						CRES_4C:  p = pal_model[{pb, word[15 - 2 * j -: 2]}];
						CRES_16C: p = pal_model[{pb[5:2], word[15 - 4 * j -: 4]}];
						default:  p = sl_pixel_t'(word[14 - 8 * j -: 7]); // high byte first
					endcase
					if (p.opaque)
						row[px_x] = p; // later sprite paints over
					px_x = px_x + 9'd1; // wraps at 512
				end
			end
		end
	end
	for (int i = 0; i < LINE_PIXELS; i++)
		ref_line[i] = row[i];
endtask

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic check_pixel(input string test, input int line, input int x,
	input sl_pixel_t exp, input sl_pixel_t act);
	if (act !== exp)
		stop_run($sformatf("mismatch %s line %0d x %0d: expected %h actual %h",
			test, line, x, exp, act));
endtask

task automatic check_vline(input string test, input vline_t exp, input vline_t act);
	if (act !== exp)
		stop_run($sformatf("mismatch %s vline: expected %0d actual %0d", test, exp, act));
endtask

task automatic check_count(input string test, input string what, input int exp, input int act);
	if (act != exp)
		stop_run($sformatf("mismatch %s %s: expected %0d actual %0d", test, what, exp, act));
endtask

// ----------------------------------------------------------------------
// line timing
// ----------------------------------------------------------------------
task automatic wait_idle();
	int n;
	n = 0;
	while (render_busy !== 1'b1)               // render starts just after line_go
	begin
		@(negedge clk);
		n++;
		if (n > 40)
			stop_run("render_busy did not rise after the reset");
	end
	while (render_busy !== 1'b0)
	begin
		@(negedge clk);
		n++;
		if (n > LINE_CLOCKS)
			stop_run("timeout waiting for render_busy to fall");
	end
endtask

task automatic run_line(input logic first);
	int t;
	@(negedge clk);
	line_start = 1'b1;
	pre_vline  = first;
	line_first = strobe_total;
	@(negedge clk);
	line_start = 1'b0;
	t = 2;
	while (render_busy !== 1'b1)
	begin
		@(negedge clk);
		t++;
		if (t > 40)
			stop_run("render_busy did not rise after the line start");
	end
	pre_vline = 1'b0;                         // sampled already
	while (render_busy !== 1'b0)
	begin
		@(negedge clk);
		t++;
		if (t > LINE_CLOCKS)
			stop_run("timeout waiting for the render to finish");
	end
	while (strobe_total - line_first < LINE_PIXELS)
	begin
		@(negedge clk);
		t++;
		if (t > LINE_CLOCKS)
			stop_run("timeout waiting for the display pass to finish");
	end
	while (t < LINE_CLOCKS)
	begin
		@(negedge clk);
		t++;
	end
endtask

// renders lines 0..nlines-1 and checks each on the line after
task automatic run_frame(input string name, input int nlines, input logic check_pix);
	sl_pixel_t exp_cur [LINE_PIXELS];
	for (int l = 0; l <= nlines; l++)
	begin
		build_ref(vline_t'(l));
		run_line(l == 0);
		check_vline(name, vline_t'(l), u_sprite_unit.vline);
		check_count(name, "strobes", LINE_PIXELS, strobe_total - line_first);
		if (check_pix && l > 0)
			for (int i = 0; i < LINE_PIXELS; i++)
				check_pixel(name, l - 1, i, exp_cur[i], shown[i]);
		exp_cur = ref_line;
	end
endtask

// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------
task automatic test_single_4c();
	write_pal(8'h28, sl_pixel_t'(7'h3F));  // colour set, opaque clear
	write_pal(8'h29, sl_pixel_t'(7'h51));
	write_pal(8'h2A, sl_pixel_t'(7'h62));
	write_pal(8'h2B, sl_pixel_t'(7'h73));
	words[21'h01000] = 16'h1B4E;
	words[21'h01001] = 16'hE4C7;
	set_sprite(5'd5, 9'd40, 9'd0, 7'd2, 7'd1, 6'h0A, CRES_4C, 21'h01000);
	run_frame("single_4c", 2, 1'b1);
	clear_sprites();
endtask

task automatic test_overlap_16c();
	for (int i = 0; i < 16; i++)
	begin
		write_pal(8'(8'h20 + i), (i == 0) ? '0 : sl_pixel_t'({1'b1, 6'(6'h10 + i)}));
		write_pal(8'(8'h30 + i), (i == 0 || i == 5) ? '0 : sl_pixel_t'({1'b1, 6'(6'h30 + i)}));
	end
	words[21'h02000] = 16'h1234;
	words[21'h02001] = 16'h5078;               // nibble 0 shows background
	words[21'h02100] = 16'hA50C;               // 5 and 0 let sprite 3 through
	words[21'h02101] = 16'h0B00;
	set_sprite(5'd3, 9'd100, 9'd0, 7'd2, 7'd1, 6'h08, CRES_16C, 21'h02000);
	set_sprite(5'd7, 9'd104, 9'd0, 7'd2, 7'd1, 6'h0C, CRES_16C, 21'h02100);
	run_frame("overlap_16c", 2, 1'b1);
	clear_sprites();
endtask

task automatic test_tc_wrap();
	logic [7:0] hi, lo;
	for (int k = 0; k < 8; k++)
	begin
		hi = {2'b01, 6'(6'h20 + 2 * k)};
		lo = (k % 3 == 1) ? 8'h15 : {2'b01, 6'(6'h21 + 2 * k)}; // some bytes transparent
		words[MEM_AW'(21'h03000 + k)] = {hi, lo};
	end
	set_sprite(5'd10, 9'd500, 9'd0, 7'd8, 7'd1, 6'h00, CRES_TC, 21'h03000);
	run_frame("tc_wrap", 2, 1'b1);
	clear_sprites();
endtask

task automatic test_tall();
	for (int k = 0; k < 10; k++)
		words[MEM_AW'(21'h04000 + k)] = {4'(k + 1), 4'(k + 2), 4'(k + 3), 4'(k + 1)};
	set_sprite(5'd20, 9'd200, 9'd2, 7'd2, 7'd1, 6'h08, CRES_16C, 21'h04000);
	run_frame("tall", 8, 1'b1);                // lines 2..5 in range
	clear_sprites();
endtask

task automatic test_off_clear();
	for (int k = 0; k < 4; k++)
		words[MEM_AW'(21'h05000 + k)] = 16'hFFFF ^ 16'(k << 4);
	set_sprite(5'd0, 9'd10, 9'd0, 7'd2, 7'd1, 6'h0A, CRES_OFF, 21'h01000);
	set_sprite(5'd1, 9'd300, 9'd0, 7'd1, 7'd1, 6'h0A, CRES_4C, 21'h05000);
	run_frame("off_clear", 6, 1'b1);           // lines 4 and 5 blank
	clear_sprites();
endtask

`endif

//--- dv/tb_sprite_unit.sv
`default_nettype none

module tb_sprite_unit
	import sprite_pkg::*;
();

	localparam int LINE_CLOCKS = 1800; // clocks per video line

	typedef struct packed {
		logic [15:0] data;
		int          due;  // cycle from which the response may be driven
	} rsp_ent_t;

	logic     clk = 1'b0;
	logic     line_start;
	logic     pre_vline;
	cfg_wr_t  cfg;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	pix_out_t pix;
	logic     render_busy;

	// memory model state
	logic [15:0] words [logic [MEM_AW-1:0]]; // sparse word memory
	rsp_ent_t    rsp_q [$];                  // in-order responses
	int          outstanding = 0;
	int          cyc = 0;
	int          seed = 26571;

	// display capture
	int          strobe_total = 0;
	int          line_first = 0;             // strobe_total at line start
	sl_pixel_t   shown [LINE_PIXELS];

	always #5 clk = ~clk;

	sprite_unit u_sprite_unit (
		.clk         (clk),
		.line_start  (line_start),
		.pre_vline   (pre_vline),
		.cfg         (cfg),
		.mem_req     (mem_req),
		.mem_rsp     (mem_rsp),
		.pix         (pix),
		.render_busy (render_busy)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	`include "sprite_tb_tasks.svh"

	// ------------------------------------------------------------------
	// memory model, sampled on the rising edge
	// ------------------------------------------------------------------
	always @(posedge clk)
	begin : mem_accept
		int       delay;
		rsp_ent_t ent;
		if (line_start)
		begin
			rsp_q.delete();  // reads in flight are dropped
			outstanding = 0;
		end
		else
		begin
			if (mem_req.valid === 1'b1 && outstanding >= MEM_CREDITS)
				stop_run("memory request issued while all credits were in use");
			if (mem_rsp.valid)
			begin
				void'(rsp_q.pop_front()); // head taken by the engine
				outstanding = outstanding - 1;
			end
			if (mem_req.valid === 1'b1)
			begin
				delay    = $unsigned($random(seed)) % 4;
				ent.data = read_word(mem_req.addr);
				ent.due  = cyc + 1 + delay; // at least one cycle later
				rsp_q.push_back(ent);
				outstanding = outstanding + 1;
			end
		end
		cyc = cyc + 1;
	end

	// responses driven on the falling edge
	always @(negedge clk)
		if (rsp_q.size() != 0 && rsp_q[0].due <= cyc)
			mem_rsp = '{valid: 1'b1, data: rsp_q[0].data};
		else
			mem_rsp = '0;

	// display strobes
	always @(posedge clk)
		if (pix.strobe === 1'b1)
		begin
			if (strobe_total - line_first < LINE_PIXELS)
				shown[strobe_total - line_first] = pix.en ? sl_pixel_t'({1'b1, pix.color}) : '0;
			strobe_total = strobe_total + 1;
		end

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial
	begin
		line_start = 1'b1;
		pre_vline  = 1'b1;   // first line after reset starts a frame
		cfg        = '0;
		mem_rsp    = '0;
		repeat (10) @(negedge clk);
		line_start = 1'b0;
		wait_idle();         // render of uninitialised attributes
		init_config();
		run_frame("warmup", 2, 1'b0); // both banks cleared once
		test_single_4c();
		test_overlap_16c();
		test_tc_wrap();
		test_tall();
		test_off_clear();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+dv
source/sprite_pkg.sv
source/sprite_ram.sv
source/sprite_line_sequencer.sv
source/sprite_line_buffer.sv
source/sprite_engine.sv
source/sprite_unit.sv
dv/tb_sprite_unit.sv

//--- source/sprite_engine.sv
`default_nettype none

module sprite_engine
	import sprite_pkg::*;
(
	input  logic              clk,
	input  logic              line_start,
	input  logic              line_go,
	input  vline_t            vline,
	input  logic              render_bank,
	output logic [7:0]        attr_raddr,
	input  logic [7:0]        attr_rdata,
	output logic [7:0]        pal_raddr,
	input  sl_pixel_t         pal_rdata,
	output logic [SPR_AW-1:0] offs_raddr,
	output logic [SPR_AW-1:0] offs_waddr,
	input  logic [MEM_AW-1:0] offs_rdata,
	output logic              offs_we,
	output logic [MEM_AW-1:0] offs_wdata,
	output mem_req_t          mem_req,
	input  mem_rsp_t          mem_rsp,
	output lb_wr_t            lb_wr,
	output logic              render_busy
);

	localparam int CW = $clog2(MEM_CREDITS + 1);
	localparam int RW = $clog2(MEM_CREDITS);

	typedef enum logic [2:0] {S_IDLE, S_RD, S_CHECK, S_SETUP, S_FETCH} state_e;

	state_e            state;
	logic [SPR_AW-1:0] num;      // sprite being walked
	logic [3:0]        rd_cnt;   // attribute byte counter, 0..8
	logic [7:0][7:0]   ab;       // attribute bytes of this sprite

	logic [8:0]        spr_x, spr_y;
	logic [6:0]        spr_w, spr_h;
	logic [5:0]        pal_base;
	cres_e             cres;
	logic [MEM_AW-1:0] spr_base;
	logic              vis, last_spr, next_spr, spr_done;

	logic [MEM_AW-1:0] offs, req_addr;
	logic [6:0]        req_left;  // words still to request
	logic [CW-1:0]     credits, rx_cnt;
	logic [RW-1:0]     rx_wp, rx_rp;
	logic [15:0]       rx_buf [MEM_CREDITS];
	logic              req_fire, rx_pop, emit;
	logic [15:0]       sh;        // unpack shifter, msb pixel first
	logic [3:0]        pix_left, ppw, bpp;
	logic [8:0]        x_cur;

	logic              p1_valid, p1_tc;
	logic [8:0]        p1_x;
	sl_pixel_t         p1_tcpix, px;

	// ----------------------------------------------------------------------
	// attribute decode
	// ----------------------------------------------------------------------
	assign spr_x    = {ab[1][7], ab[0]};
	assign spr_w    = ab[1][6:0];
	assign spr_y    = {ab[3][7], ab[2]};
	assign spr_h    = ab[3][6:0];          // in units of 4 lines
	assign pal_base = ab[4][7:2];
	assign cres     = cres_e'(ab[4][1:0]);
	assign spr_base = {ab[7][4:0], ab[6], ab[5]};
	assign vis      = (vline >= spr_y) &&
	                  ({1'b0, vline} < ({1'b0, spr_y} + {1'b0, spr_h, 2'b00}));

	assign attr_raddr = {num, rd_cnt[2:0]};
	assign offs_raddr = num;
	assign offs_waddr = num;
	assign offs_we    = (state == S_SETUP);
	assign offs_wdata = offs + MEM_AW'(spr_w); // next line starts here

	// fetch and unpack handshakes
	assign req_fire = (state == S_FETCH) && (req_left != '0) && (rx_cnt < credits);
	assign mem_req  = '{valid: req_fire, addr: req_addr};
	assign emit     = (pix_left != '0);
	assign rx_pop   = (state == S_FETCH) && (rx_cnt != '0) && (pix_left <= 4'd1);
	assign last_spr = (num == SPR_AW'(NUM_SPRITES - 1));
	assign spr_done = (req_left == '0) && (credits == CW'(MEM_CREDITS)) &&
	                  (rx_cnt == '0) && !emit;
	assign next_spr = ((state == S_CHECK) && ((cres == CRES_OFF) || !vis)) ||
	                  ((state == S_FETCH) && spr_done);

	// pixels per word, bits per pixel, palette index
	always_comb
		case (cres)
			CRES_4C:
			begin
				ppw       = 4'd8;
				bpp       = 4'd2;
				pal_raddr = {pal_base, sh[15:14]};
			end
			CRES_16C:
			begin
				ppw       = 4'd4;
				bpp       = 4'd4;
				pal_raddr = {pal_base[5:2], sh[15:12]};
			end
			default:
			begin
				ppw       = 4'd2;            // true colour, no palette
				bpp       = 4'd8;
				pal_raddr = {pal_base, sh[15:14]};
			end
		endcase

	// ----------------------------------------------------------------------
	// sprite walk FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	if (line_start)
	begin
		state  <= S_IDLE; // abort unfinished render
		num    <= '0;
		rd_cnt <= '0;
	end
	else if (next_spr)
	begin
		num    <= num + 1'b1;
		rd_cnt <= '0;
		state  <= last_spr ? S_IDLE : S_RD;
	end
	else
		case (state)
			S_IDLE:
				if (line_go)
				begin
					num    <= '0;
					rd_cnt <= '0;
					state  <= S_RD;
				end
			S_RD:
			begin
				rd_cnt <= rd_cnt + 4'd1;
				if (rd_cnt == 4'd8)
					state <= S_CHECK;
			end
			S_CHECK: state <= S_SETUP;  // visible, not off
			S_SETUP: state <= S_FETCH;
			default: state <= state;    // S_FETCH until spr_done
		endcase

	// ----------------------------------------------------------------------
	// credits, rx fifo, counters
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	if (line_start)
	begin
		credits  <= CW'(MEM_CREDITS);
		rx_cnt   <= '0;
		rx_wp    <= '0;
		rx_rp    <= '0;
		req_left <= '0;
		pix_left <= '0;
		p1_valid <= 1'b0;
	end
	else
	begin
		credits <= credits - CW'(req_fire) + CW'(mem_rsp.valid);
		rx_cnt  <= rx_cnt + CW'(mem_rsp.valid) - CW'(rx_pop);
		if (mem_rsp.valid)
			rx_wp <= rx_wp + 1'b1;
		if (rx_pop)
			rx_rp <= rx_rp + 1'b1;
		if (state == S_SETUP)
			req_left <= spr_w;
		else if (req_fire)
			req_left <= req_left - 7'd1;
		if (rx_pop)
			pix_left <= ppw;             // next word, back to back
		else if (emit)
			pix_left <= pix_left - 4'd1;
		p1_valid <= emit;
	end

	// datapath
	always_ff @(posedge clk)
	begin
		if ((state == S_RD) && (rd_cnt != 4'd0))
			ab[3'(rd_cnt - 4'd1)] <= attr_rdata; // byte addressed last clock
		if (mem_rsp.valid)
			rx_buf[rx_wp] <= mem_rsp.data;
		if (state == S_CHECK)
			offs <= (vline == spr_y) ? '0 : offs_rdata; // first line restarts
		if (state == S_SETUP)
		begin
			req_addr <= spr_base + offs;
			x_cur    <= spr_x;
		end
		else
		begin
			if (req_fire)
				req_addr <= req_addr + 1'b1;
			if (emit)
				x_cur <= x_cur + 9'd1;         // wraps at 512
		end
		if (rx_pop)
			sh <= rx_buf[rx_rp];
		else if (emit)
			sh <= sh << bpp;
		p1_x     <= x_cur;
		p1_tc    <= (cres == CRES_TC);
		p1_tcpix <= sl_pixel_t'(sh[14:8]);   // high byte first
	end

	// stage 1, palette data is back
	assign px          = p1_tc ? p1_tcpix : pal_rdata;
	assign lb_wr       = '{we: p1_valid && px.opaque, bank: render_bank, x: p1_x, pix: px};
	assign render_busy = (state != S_IDLE) || p1_valid;

	// every response hands back a credit that a request spent
	a_credit: assert property (@(posedge clk) disable iff (line_start)
		mem_rsp.valid |-> (credits != CW'(MEM_CREDITS)))
		else $error("memory response with no read outstanding");

endmodule

`default_nettype wire

//--- source/sprite_line_buffer.sv
`default_nettype none

module sprite_line_buffer
	import sprite_pkg::*;
(
	input  logic     clk,
	input  logic     line_start,
	input  logic     line_go,
	input  logic     render_bank,
	input  lb_wr_t   lb_wr,
	output pix_out_t pix
);

	localparam int XW = $clog2(LB_DEPTH);
	localparam int PW = $clog2(PIX_CYCLES);

	logic          disp_bank; // bank being shown
	logic          active;
	logic          rd_fire;   // read + clear this clock
	logic          strobe_q;
	logic [PW-1:0] pace;
	logic [XW-1:0] rd_ptr;
	sl_pixel_t     rd_pix [2];

	assign disp_bank = ~render_bank;
	assign rd_fire   = active && (pace == '0);

	// ----------------------------------------------------------------------
	// display pacing, one position every PIX_CYCLES clocks
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	if (line_start)
	begin
		active   <= 1'b0;
		pace     <= '0;
		rd_ptr   <= '0;
		strobe_q <= 1'b0;
	end
	else
	begin
		strobe_q <= rd_fire; // data lands one clock after the read
		if (line_go)
		begin
			active <= 1'b1;
			pace   <= '0;
			rd_ptr <= '0;
		end
		else if (active)
		begin
			pace <= (pace == PW'(PIX_CYCLES - 1)) ? '0 : pace + 1'b1;
			if (rd_fire)
			begin
				rd_ptr <= rd_ptr + 1'b1;
				if (rd_ptr == XW'(LINE_PIXELS - 1))
					active <= 1'b0; // last position of the line
			end
		end
	end

	// ----------------------------------------------------------------------
	// two banks, render writes win the port, display clears the other
	// ----------------------------------------------------------------------
	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		sl_pixel_t     mem [LB_DEPTH];
		sl_pixel_t     rd_q;
		sl_pixel_t     wr_d;
		logic [XW-1:0] wr_x;
		logic          rend;
		logic          wr_en;

		assign rend  = lb_wr.we && (lb_wr.bank == 1'(b));
		assign wr_en = rend || (rd_fire && (disp_bank == 1'(b)));
		assign wr_x  = rend ? lb_wr.x : rd_ptr;
		assign wr_d  = rend ? lb_wr.pix : '0; // transparent after read

		always_ff @(posedge clk)
		begin
			if (wr_en)
				mem[wr_x] <= wr_d;
			rd_q <= mem[rd_ptr]; // read-first, sees the entry before clear
		end

		assign rd_pix[b] = rd_q;
	end

	assign pix = '{strobe: strobe_q,
	               en:     rd_pix[disp_bank].opaque,
	               color:  rd_pix[disp_bank].color};

	a_no_disp_write: assert property (@(posedge clk) disable iff (line_start)
		lb_wr.we |-> (lb_wr.bank == render_bank))
		else $error("render write aimed at display bank");

endmodule

`default_nettype wire

//--- source/sprite_line_sequencer.sv
`default_nettype none

module sprite_line_sequencer
	import sprite_pkg::*;
(
	input  logic   clk,
	input  logic   line_start,
	input  logic   pre_vline,
	output vline_t vline,
	output logic   render_bank,
	output logic   line_go
);

	logic armed; // line_start seen, waiting for it to drop

	always_ff @(posedge clk or posedge line_start)
	if (line_start)
	begin
		armed   <= 1'b1;
		line_go <= 1'b0;
	end
	else
	begin
		line_go <= armed; // single pulse, aligned with new vline
		armed   <= 1'b0;
	end

	// line count and bank parity survive line_start
	always_ff @(posedge clk)
		if (armed && !line_start)
		begin
			vline       <= pre_vline ? '0 : vline + 9'd1; // frame restart
			render_bank <= ~render_bank;
		end

endmodule

`default_nettype wire

//--- source/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// ----------------------------------------------------------------------
	// sizes and timing
	// ----------------------------------------------------------------------
	localparam int NUM_SPRITES = 32;                  // sprite list length
	localparam int MEM_CREDITS = 2;                   // max reads in flight
	localparam int PIX_CYCLES  = 4;                   // clocks per shown pixel
	localparam int LINE_PIXELS = 360;                 // shown positions per line
	localparam int LB_DEPTH    = 512;                 // entries per bank
	localparam int SPR_AW      = $clog2(NUM_SPRITES); // sprite number width
	localparam int MEM_AW      = 21;                  // word address, 2M x 16

	// cfg target select
	localparam logic [1:0] CFG_SEL_ATTR = 2'd0;
	localparam logic [1:0] CFG_SEL_PAL  = 2'd1;

	// ----------------------------------------------------------------------
	// types
	// ----------------------------------------------------------------------
	typedef logic [8:0] vline_t;

	typedef enum logic [1:0] {
		CRES_OFF = 2'd0,
		CRES_4C  = 2'd1,
		CRES_16C = 2'd2,
		CRES_TC  = 2'd3
	} cres_e;

	// line buffer entry, also palette entry (opaque clear = transparent)
	typedef struct packed {
		logic       opaque;
		logic [5:0] color;
	} sl_pixel_t;

	typedef struct packed {
		logic       we;
		logic [1:0] sel;   // CFG_SEL_*
		logic [7:0] addr;
		logic [7:0] data;
	} cfg_wr_t;

	typedef struct packed {
		logic              valid;
		logic [MEM_AW-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] data;
	} mem_rsp_t;

	typedef struct packed {
		logic       we;
		logic       bank;
		logic [8:0] x;
		sl_pixel_t  pix;
	} lb_wr_t;

	typedef struct packed {
		logic       strobe;
		logic       en;
		logic [5:0] color;
	} pix_out_t;

endpackage

`default_nettype wire

//--- source/sprite_ram.sv
`default_nettype none

module sprite_ram #(
	parameter type word_t = logic [7:0],
	parameter int  DEPTH  = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  word_t                    wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output word_t                    rdata
);

	word_t mem [DEPTH];

	// one write port, registered read
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // old data on same-address write
	end

	// non power of two depths leave a hole at the top
	a_waddr_range: assert property (@(posedge clk) we |-> (waddr < DEPTH))
		else $error("sprite_ram write beyond depth");

endmodule

`default_nettype wire

//--- source/sprite_unit.sv
`default_nettype none

module sprite_unit
	import sprite_pkg::*;
(
	input  logic     clk,
	input  logic     line_start,
	input  logic     pre_vline,
	input  cfg_wr_t  cfg,
	output mem_req_t mem_req,
	input  mem_rsp_t mem_rsp,
	output pix_out_t pix,
	output logic     render_busy
);

	vline_t            vline;
	logic              render_bank, line_go;
	logic [7:0]        attr_raddr, attr_rdata, pal_raddr;
	sl_pixel_t         pal_rdata;
	logic [SPR_AW-1:0] offs_raddr, offs_waddr;
	logic [MEM_AW-1:0] offs_rdata, offs_wdata;
	logic              offs_we, attr_we, pal_we;
	lb_wr_t            lb_wr;

	// cfg decode
	assign attr_we = cfg.we && (cfg.sel == CFG_SEL_ATTR);
	assign pal_we  = cfg.we && (cfg.sel == CFG_SEL_PAL);

	sprite_line_sequencer u_seq (
		.clk         (clk),
		.line_start  (line_start),
		.pre_vline   (pre_vline),
		.vline       (vline),
		.render_bank (render_bank),
		.line_go     (line_go)
	);

	sprite_engine u_engine (
		.clk         (clk),
		.line_start  (line_start),
		.line_go     (line_go),
		.vline       (vline),
		.render_bank (render_bank),
		.attr_raddr  (attr_raddr),
		.attr_rdata  (attr_rdata),
		.pal_raddr   (pal_raddr),
		.pal_rdata   (pal_rdata),
		.offs_raddr  (offs_raddr),
		.offs_waddr  (offs_waddr),
		.offs_rdata  (offs_rdata),
		.offs_we     (offs_we),
		.offs_wdata  (offs_wdata),
		.mem_req     (mem_req),
		.mem_rsp     (mem_rsp),
		.lb_wr       (lb_wr),
		.render_busy (render_busy)
	);

	sprite_line_buffer u_lbuf (
		.clk         (clk),
		.line_start  (line_start),
		.line_go     (line_go),
		.render_bank (render_bank),
		.lb_wr       (lb_wr),
		.pix         (pix)
	);

	// ----------------------------------------------------------------------
	// attribute file, palette, per-sprite word offsets
	// ----------------------------------------------------------------------
	sprite_ram #(.word_t(logic [7:0]), .DEPTH(256)) u_attr_ram (
		.clk   (clk),
		.we    (attr_we),
		.waddr (cfg.addr),
		.wdata (cfg.data),
		.raddr (attr_raddr),
		.rdata (attr_rdata)
	);

	sprite_ram #(.word_t(sl_pixel_t), .DEPTH(256)) u_pal_ram (
		.clk   (clk),
		.we    (pal_we),
		.waddr (cfg.addr),
		.wdata (sl_pixel_t'(cfg.data[6:0])), // bit 6 opaque
		.raddr (pal_raddr),
		.rdata (pal_rdata)
	);

	sprite_ram #(.word_t(logic [MEM_AW-1:0]), .DEPTH(NUM_SPRITES)) u_offs_ram (
		.clk   (clk),
		.we    (offs_we),
		.waddr (offs_waddr),
		.wdata (offs_wdata),
		.raddr (offs_raddr),
		.rdata (offs_rdata)
	);

endmodule

`default_nettype wire
